//--- Makefile
SIM := verilator
TOP := gpu_display_tb
FILELIST := gpu_display_top.f
BUILD_DIR := obj_dir
SIM_FLAGS := --binary --timing -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- gpu_display_top.f
source/display_timing_pkg.sv
source/frame_memory_pkg.sv
source/pixel_fifo_if.sv
source/vga_timing_gen.sv
source/frame_fetch_ctrl.sv
source/pixel_fifo.sv
source/color_palette.sv
source/gpu_display_top.sv
testbench/gpu_display_tb.sv

//--- source/color_palette.sv
`timescale 1ns/1ps
`default_nettype none

module color_palette (
    input logic gpu_clk_i,
    input logic reset_i,
    input logic wr_en_i,
    input logic [frame_memory_pkg::INDEX_BITS-1:0] wr_index_i,
    input logic [frame_memory_pkg::COLOR_BITS-1:0] wr_color_i,
    input logic pop_i,
    input logic [frame_memory_pkg::INDEX_BITS-1:0] rd_index_i,
    output logic [frame_memory_pkg::COLOR_BITS-1:0] rgb_o
);
    import frame_memory_pkg::*;

    logic [COLOR_BITS-1:0] colors [PALETTE_LENGTH];
    logic pop_q;

    always_ff @(posedge gpu_clk_i) begin
        if (wr_en_i) begin
            colors[wr_index_i] <= wr_color_i;
        end
    end

    // pop_q marks the cycle in which rd_index_i carries a popped index
    always_ff @(posedge gpu_clk_i) begin
        if (reset_i) begin
            pop_q <= 1'b0;
            rgb_o <= '0;
        end else begin
            pop_q <= pop_i;
            rgb_o <= pop_q ? colors[rd_index_i] : '0;
        end
    end

endmodule

`default_nettype wire

//--- source/display_timing_pkg.sv
`default_nettype none

package display_timing_pkg;

    // Horizontal raster in pixel clocks, ordered sync, back porch, visible, front porch
    localparam int H_SYNC_PXL = 4;
    localparam int H_BACK_PORCH_PXL = 2;
    localparam int H_VIS_AREA_PXL = 16;
    localparam int H_FRONT_PORCH_PXL = 2;
    localparam int H_WHOLE_LINE_PXL = H_SYNC_PXL + H_BACK_PORCH_PXL + H_VIS_AREA_PXL
                                      + H_FRONT_PORCH_PXL;

    // Vertical raster in lines
    localparam int V_SYNC_LINES = 2;
    localparam int V_BACK_PORCH_LINES = 1;
    localparam int V_VIS_AREA_LINES = 8;
    localparam int V_FRONT_PORCH_LINES = 1;
    localparam int V_WHOLE_FRAME_LINES = V_SYNC_LINES + V_BACK_PORCH_LINES + V_VIS_AREA_LINES
                                         + V_FRONT_PORCH_LINES;

    // One cycle of FIFO read plus one cycle of palette read
    localparam int SYNC_LATENCY = 2;

    localparam int DOWNSCALE_FACTOR = 2;
    localparam int RESOLUTION_X = H_VIS_AREA_PXL / DOWNSCALE_FACTOR;
    localparam int RESOLUTION_Y = V_VIS_AREA_LINES / DOWNSCALE_FACTOR;
    localparam int FRAME_PIXELS = RESOLUTION_X * RESOLUTION_Y;
    localparam int PIXEL_INDEX_BITS = $clog2(FRAME_PIXELS) + 1;

endpackage

`default_nettype wire

//--- source/frame_fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module frame_fetch_ctrl (
    input logic gpu_clk_i,
    input logic reset_i,
    input logic frame_end_i,
    output logic bram_en_o,
    output logic [frame_memory_pkg::BRAM_ADDR_BITS-1:0] bram_addr_o,
    input logic [frame_memory_pkg::BRAM_DATA_BITS-1:0] bram_dout_i,
    pixel_fifo_if.producer fifo,
    output logic pal_wr_en_o,
    output logic [frame_memory_pkg::INDEX_BITS-1:0] pal_wr_index_o,
    output logic [frame_memory_pkg::COLOR_BITS-1:0] pal_wr_color_o
);
    import display_timing_pkg::*;
    import frame_memory_pkg::*;

    fetch_state_t state;
    fetch_state_t next_state;

    logic [INDEX_BITS:0] pal_cnt;
    logic [PIXEL_INDEX_BITS-1:0] pxl_index;
    logic [$clog2(DOWNSCALE_FACTOR)-1:0] h_dup;
    logic [$clog2(DOWNSCALE_FACTOR)-1:0] v_dup;
    logic [$clog2(RESOLUTION_X)-1:0] x_index;

    logic pal_done;
    logic pxl_done;
    logic pal_rd;
    logic pxl_rd;
    logic [BRAM_ADDR_BITS-1:0] pal_addr;
    logic [BRAM_ADDR_BITS-1:0] pxl_addr;

    logic rd_pal_q;
    logic rd_pxl_q;
    logic [1:0] lane_q;
    logic [INDEX_BITS-1:0] pal_index_q;

    assign pal_done = (pal_cnt == PALETTE_LENGTH);
    assign pxl_done = (pxl_index == FRAME_PIXELS);

    // Pixel reads stop as soon as prog_full shows, leaving one read in flight
    assign pal_rd = (state == FETCH_PALETTE);
    assign pxl_rd = (state == FETCH_PIXELS) && !fifo.prog_full && !pxl_done;

    always_ff @(posedge gpu_clk_i) begin
        if (reset_i) begin
            state <= FETCH_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        if (frame_end_i) begin
            next_state = FETCH_PALETTE;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (!pal_done) begin
                        next_state = FETCH_PALETTE;
                    end else if (!pxl_done && fifo.prog_empty) begin
                        next_state = FETCH_PIXELS;
                    end
                end
                FETCH_PALETTE: begin
                    if (pal_cnt == PALETTE_LENGTH - 1) begin
                        next_state = FETCH_PIXELS;
                    end
                end
                FETCH_PIXELS: begin
                    if (fifo.prog_full || pxl_done) begin
                        next_state = FETCH_IDLE;
                    end
                end
                default: next_state = FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge gpu_clk_i) begin
        if (reset_i || frame_end_i) begin
            pal_cnt <= '0;
        end else if (pal_rd) begin
            pal_cnt <= pal_cnt + 1'b1;
        end
    end

    // Each stored pixel is read twice per line, and each row is read for two lines
    always_ff @(posedge gpu_clk_i) begin
        if (reset_i || frame_end_i) begin
            h_dup <= '0;
            v_dup <= '0;
            x_index <= '0;
            pxl_index <= '0;
        end else if (pxl_rd) begin
            if (h_dup == DOWNSCALE_FACTOR - 1) begin
                h_dup <= '0;
                if (x_index == RESOLUTION_X - 1) begin
                    x_index <= '0;
                    if (v_dup == DOWNSCALE_FACTOR - 1) begin
                        v_dup <= '0;
                        pxl_index <= pxl_index + 1'b1;
                    end else begin
                        // First pass of the row pair, so go back to the start of the row
                        v_dup <= v_dup + 1'b1;
                        pxl_index <= pxl_index - PIXEL_INDEX_BITS'(RESOLUTION_X - 1);
                    end
                end else begin
                    x_index <= x_index + 1'b1;
                    pxl_index <= pxl_index + 1'b1;
                end
            end else begin
                h_dup <= h_dup + 1'b1;
            end
        end
    end

    assign pal_addr = BRAM_ADDR_BITS'(PALETTE_BASE_ADDR)
                      + BRAM_ADDR_BITS'(BYTES_PER_COLOR * pal_cnt);
    assign pxl_addr = BRAM_ADDR_BITS'(FRAMEBUFFER_BASE_ADDR) + BRAM_ADDR_BITS'(pxl_index);

    assign bram_en_o = pal_rd || pxl_rd;
    assign bram_addr_o = pal_rd ? pal_addr : pxl_addr;

    // A read issued in the frame end cycle would land after the flush
    always_ff @(posedge gpu_clk_i) begin
        if (reset_i || frame_end_i) begin
            rd_pal_q <= 1'b0;
            rd_pxl_q <= 1'b0;
        end else begin
            rd_pal_q <= pal_rd;
            rd_pxl_q <= pxl_rd;
        end
    end

    always_ff @(posedge gpu_clk_i) begin
        lane_q <= bram_addr_o[1:0];
        pal_index_q <= pal_cnt[INDEX_BITS-1:0];
    end

    assign fifo.push = rd_pxl_q;
    assign fifo.push_index = bram_dout_i[8*lane_q +: INDEX_BITS];
    assign fifo.flush = frame_end_i;

    // Palette entries are half-word aligned
    assign pal_wr_en_o = rd_pal_q;
    assign pal_wr_index_o = pal_index_q;
    assign pal_wr_color_o = bram_dout_i[16*lane_q[1] +: COLOR_BITS];

endmodule

`default_nettype wire

//--- source/frame_memory_pkg.sv
`default_nettype none

package frame_memory_pkg;

    // Palette entries are 16-bit half-words, colour in the low 12 bits
    localparam int PALETTE_LENGTH = 16;
    localparam int INDEX_BITS = $clog2(PALETTE_LENGTH);
    localparam int COLOR_BITS = 12;
    localparam int BYTES_PER_COLOR = 2;
    localparam int PALETTE_BASE_ADDR = 0;
    localparam int PALETTE_SIZE = PALETTE_LENGTH * BYTES_PER_COLOR;

    // One byte per stored pixel right after the palette, index in the low nibble
    localparam int FRAMEBUFFER_BASE_ADDR = PALETTE_SIZE;

    // Byte addressed port returning the aligned 32-bit word
    localparam int BRAM_ADDR_BITS = 16;
    localparam int BRAM_DATA_BITS = 32;

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PROG_FULL = 12;
    localparam int FIFO_PROG_EMPTY = 4;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_PALETTE,
        FETCH_PIXELS
    } fetch_state_t;

endpackage

`default_nettype wire

//--- source/gpu_display_top.sv
`timescale 1ns/1ps
`default_nettype none

module gpu_display_top (
    input logic gpu_clk_i,
    input logic reset_i,
    output logic bram_en_o,
    output logic [frame_memory_pkg::BRAM_ADDR_BITS-1:0] bram_addr_o,
    input logic [frame_memory_pkg::BRAM_DATA_BITS-1:0] bram_dout_i,
    output logic [frame_memory_pkg::COLOR_BITS-1:0] vga_rgb_o,
    output logic vga_hs_o,
    output logic vga_vs_o
);
    import frame_memory_pkg::*;

    logic frame_end;
    logic pal_wr_en;
    logic [INDEX_BITS-1:0] pal_wr_index;
    logic [COLOR_BITS-1:0] pal_wr_color;

    pixel_fifo_if fifo_if ();

    vga_timing_gen vga_timing_gen_i (
        .gpu_clk_i(gpu_clk_i),
        .reset_i(reset_i),
        .pop_o(fifo_if.pop),
        .hs_o(vga_hs_o),
        .vs_o(vga_vs_o),
        .frame_end_o(frame_end)
    );

    frame_fetch_ctrl frame_fetch_ctrl_i (
        .gpu_clk_i(gpu_clk_i),
        .reset_i(reset_i),
        .frame_end_i(frame_end),
        .bram_en_o(bram_en_o),
        .bram_addr_o(bram_addr_o),
        .bram_dout_i(bram_dout_i),
        .fifo(fifo_if.producer),
        .pal_wr_en_o(pal_wr_en),
        .pal_wr_index_o(pal_wr_index),
        .pal_wr_color_o(pal_wr_color)
    );

    pixel_fifo pixel_fifo_i (
        .gpu_clk_i(gpu_clk_i),
        .reset_i(reset_i),
        .fifo(fifo_if.buffer)
    );

    // The palette sees the same pop as the FIFO and delays it internally
    color_palette color_palette_i (
        .gpu_clk_i(gpu_clk_i),
        .reset_i(reset_i),
        .wr_en_i(pal_wr_en),
        .wr_index_i(pal_wr_index),
        .wr_color_i(pal_wr_color),
        .pop_i(fifo_if.pop),
        .rd_index_i(fifo_if.pop_index),
        .rgb_o(vga_rgb_o)
    );

endmodule

`default_nettype wire

//--- source/pixel_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo (
    input logic gpu_clk_i,
    input logic reset_i,
    pixel_fifo_if.buffer fifo
);
    import frame_memory_pkg::*;

    logic [INDEX_BITS-1:0] mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(FIFO_DEPTH):0] count;
    logic do_push;
    logic do_pop;

    assign do_push = fifo.push && (count < FIFO_DEPTH);
    assign do_pop = fifo.pop && (count != '0);

    always_ff @(posedge gpu_clk_i) begin
        if (reset_i || fifo.flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The head index shows up on pop_index the cycle after the pop
    always_ff @(posedge gpu_clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= fifo.push_index;
        end
        if (do_pop) begin
            fifo.pop_index <= mem[rd_ptr];
        end
    end

    assign fifo.prog_full = (count >= FIFO_PROG_FULL);
    assign fifo.prog_empty = (count <= FIFO_PROG_EMPTY);

endmodule

`default_nettype wire

//--- source/pixel_fifo_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pixel_fifo_if;
    import frame_memory_pkg::*;

    logic push;
    logic [INDEX_BITS-1:0] push_index;
    logic prog_full;
    logic prog_empty;
    logic flush;
    logic pop;
    logic [INDEX_BITS-1:0] pop_index;

    modport producer (output push, output push_index, output flush,
                      input prog_full, input prog_empty);
    modport buffer (input push, input push_index, input flush, input pop,
                    output prog_full, output prog_empty, output pop_index);
    modport consumer (output pop, input pop_index);
endinterface

`default_nettype wire

//--- source/vga_timing_gen.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing_gen (
    input logic gpu_clk_i,
    input logic reset_i,
    output logic pop_o,
    output logic hs_o,
    output logic vs_o,
    output logic frame_end_o
);
    import display_timing_pkg::*;

    logic [$clog2(H_WHOLE_LINE_PXL)-1:0] h_cnt;
    logic [$clog2(V_WHOLE_FRAME_LINES)-1:0] v_cnt;
    logic h_last;
    logic v_last;
    logic h_vis;
    logic v_vis;
    logic [SYNC_LATENCY-1:0] hs_dly;
    logic [SYNC_LATENCY-1:0] vs_dly;

    assign h_last = (h_cnt == H_WHOLE_LINE_PXL - 1);
    assign v_last = (v_cnt == V_WHOLE_FRAME_LINES - 1);

    always_ff @(posedge gpu_clk_i) begin
        if (reset_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign h_vis = (h_cnt >= H_SYNC_PXL + H_BACK_PORCH_PXL)
                   && (h_cnt < H_SYNC_PXL + H_BACK_PORCH_PXL + H_VIS_AREA_PXL);
    assign v_vis = (v_cnt >= V_SYNC_LINES + V_BACK_PORCH_LINES)
                   && (v_cnt < V_SYNC_LINES + V_BACK_PORCH_LINES + V_VIS_AREA_LINES);

    // The pop request leads the colour by the FIFO and palette read stages
    assign pop_o = h_vis && v_vis;
    assign frame_end_o = h_last && v_last;

    // Syncs are delayed to line up with the colour coming out of the palette
    always_ff @(posedge gpu_clk_i) begin
        if (reset_i) begin
            hs_dly <= '0;
            vs_dly <= '0;
        end else begin
            hs_dly <= {hs_dly[SYNC_LATENCY-2:0], h_cnt < H_SYNC_PXL};
            vs_dly <= {vs_dly[SYNC_LATENCY-2:0], v_cnt < V_SYNC_LINES};
        end
    end

    assign hs_o = hs_dly[SYNC_LATENCY-1];
    assign vs_o = vs_dly[SYNC_LATENCY-1];

endmodule

`default_nettype wire

//--- testbench/gpu_display_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gpu_display_tb;
    import display_timing_pkg::*;
    import frame_memory_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_FRAMES = 3;
    localparam int FRAME_CYCLES = H_WHOLE_LINE_PXL * V_WHOLE_FRAME_LINES;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + (NUM_FRAMES + 1) * FRAME_CYCLES + 100;
    localparam int MEM_WORDS = (FRAMEBUFFER_BASE_ADDR + FRAME_PIXELS) / 4;
    localparam int H_VIS_START = H_SYNC_PXL + H_BACK_PORCH_PXL;
    localparam int V_VIS_START = V_SYNC_LINES + V_BACK_PORCH_LINES;

    logic gpu_clk_i = 1'b0;
    logic reset_i;
    logic bram_en_o;
    logic [BRAM_ADDR_BITS-1:0] bram_addr_o;
    logic [BRAM_DATA_BITS-1:0] bram_dout_i;
    logic [COLOR_BITS-1:0] vga_rgb_o;
    logic vga_hs_o;
    logic vga_vs_o;

    logic [31:0] mem [MEM_WORDS];
    integer seed;

    int cycle_cnt = 0;
    int h_pos = 0;
    int line = 0;
    int last_hs_rise = 0;
    int last_vs_rise = 0;
    int hs_len = 0;
    int vs_len = 0;
    int frames_done = 0;
    logic hs_prev = 1'b0;
    logic vs_prev = 1'b0;
    logic hs_seen = 1'b0;
    logic vs_seen = 1'b0;

    gpu_display_top gpu_display_top_i (
        .gpu_clk_i(gpu_clk_i),
        .reset_i(reset_i),
        .bram_en_o(bram_en_o),
        .bram_addr_o(bram_addr_o),
        .bram_dout_i(bram_dout_i),
        .vga_rgb_o(vga_rgb_o),
        .vga_hs_o(vga_hs_o),
        .vga_vs_o(vga_vs_o)
    );

    always #(CLK_PERIOD / 2) gpu_clk_i = ~gpu_clk_i;

    task automatic stop_run(input string reason);
        $display("%s at %0t", reason, $time);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [7:0] mem_byte(input int addr);
        logic [31:0] word;
        word = mem[addr / 4];
        return word[8 * (addr % 4) +: 8];
    endfunction

    // Colour of visible pixel (x, y) after the 2x2 upscale, taken from the local memory copy
    function automatic logic [COLOR_BITS-1:0] expected_rgb(input int x, input int y);
        int fb_addr;
        int pal_addr;
        logic [7:0] index_byte;
        logic [15:0] color_half;
        fb_addr = FRAMEBUFFER_BASE_ADDR + (y / DOWNSCALE_FACTOR) * RESOLUTION_X
                  + x / DOWNSCALE_FACTOR;
        index_byte = mem_byte(fb_addr);
        pal_addr = PALETTE_BASE_ADDR + BYTES_PER_COLOR * int'(index_byte[INDEX_BITS-1:0]);
        color_half = {mem_byte(pal_addr + 1), mem_byte(pal_addr)};
        return color_half[COLOR_BITS-1:0];
    endfunction

    // Word 0 holds palette entries 0 and 1, already fetched once the delayed sync rises
    task automatic refresh_memory_contents();
        for (int i = 1; i < MEM_WORDS; i++) begin
            mem[i] = $random(seed);
        end
    endtask

    // Block RAM model with one cycle of read latency
    always @(posedge gpu_clk_i) begin
        if (bram_en_o === 1'b1) begin
            if (int'(bram_addr_o) >= 4 * MEM_WORDS) begin
                stop_run("Memory read outside the modelled address range");
            end else begin
                bram_dout_i <= mem[int'(bram_addr_o) / 4];
            end
        end
    end

    always @(negedge gpu_clk_i) begin
        if (reset_i) begin
            check_value(bram_en_o, 0, "bram_en_o during reset");
            check_value(vga_hs_o, 0, "vga_hs_o during reset");
            check_value(vga_vs_o, 0, "vga_vs_o during reset");
            check_value(vga_rgb_o, 0, "vga_rgb_o during reset");
        end else begin
            cycle_cnt++;
            h_pos++;
            if (vga_hs_o && !hs_prev) begin
                if (hs_seen) begin
                    check_value(cycle_cnt - last_hs_rise, H_WHOLE_LINE_PXL, "hsync period");
                end
                hs_seen = 1'b1;
                last_hs_rise = cycle_cnt;
                h_pos = 0;
                hs_len = 0;
                line++;
            end
            if (vga_hs_o) begin
                hs_len++;
            end else if (hs_prev) begin
                check_value(hs_len, H_SYNC_PXL, "hsync pulse width");
            end
            if (vga_vs_o && !vs_prev) begin
                if (vs_seen) begin
                    check_value(cycle_cnt - last_vs_rise, FRAME_CYCLES, "vsync period");
                    frames_done++;
                end
                vs_seen = 1'b1;
                last_vs_rise = cycle_cnt;
                line = 0;
                vs_len = 0;
                refresh_memory_contents();
            end
            if (vga_vs_o) begin
                vs_len++;
            end else if (vs_prev) begin
                check_value(vs_len, V_SYNC_LINES * H_WHOLE_LINE_PXL, "vsync pulse width");
            end
            if (vs_seen && line >= V_VIS_START && line < V_VIS_START + V_VIS_AREA_LINES
                    && h_pos >= H_VIS_START && h_pos < H_VIS_START + H_VIS_AREA_PXL) begin
                check_value(vga_rgb_o, expected_rgb(h_pos - H_VIS_START, line - V_VIS_START),
                            $sformatf("colour at x %0d y %0d", h_pos - H_VIS_START,
                                      line - V_VIS_START));
            end else begin
                check_value(vga_rgb_o, 0, "colour outside the visible area");
            end
            hs_prev = vga_hs_o;
            vs_prev = vga_vs_o;
        end
    end

    initial begin
        seed = 32'hb153;
        reset_i = 1'b1;
        bram_dout_i = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = $random(seed);
        end
        repeat (RESET_CYCLES) @(posedge gpu_clk_i);
        reset_i <= 1'b0;
        wait (frames_done == NUM_FRAMES);
        $display("Simulation finished: PASS");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_run("Watchdog expired before all frames were checked");
    end

endmodule

`default_nettype wire
